// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_alu.sv
  - verilog/rv_regfile.sv
  - verilog/rv_controller.sv
  - verilog/rv_datapath.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - verif/rv_core_sva.sv
      - verif/rv_core_tb.sv

// ==== sources.f ====
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_controller.sv
verilog/rv_datapath.sv
verilog/rv_core.sv
verif/rv_core_sva.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_sva.sv ====
`timescale 1ns/1ps

module rv_core_sva (
    input logic              clk,
    input logic              rst,
    input rv_pkg::rv_state_e state,
    input logic              m_we,
    input logic              rf_we
);

    int unsigned err_count = 0;

    property we_only_in_write;    // one write cycle right after the address phase
        @(posedge clk) disable iff (rst)
            m_we |-> $past(state) == rv_pkg::MEM_ADDR ##1 !m_we;
    endproperty

    property fetch_then_decode;
        @(posedge clk) disable iff (rst)
            !rst && state == rv_pkg::FETCH |=> state == rv_pkg::DECODE;
    endproperty

    property error_is_final;    // only reset leaves it
        @(posedge clk) disable iff (rst)
            state == rv_pkg::ERROR |=> state == rv_pkg::ERROR;
    endproperty

    property no_rf_write_in_fetch;
        @(posedge clk) disable iff (rst)
            state == rv_pkg::FETCH |-> !rf_we;
    endproperty

    we_only_in_write_a: assert property (we_only_in_write)
        else begin
            $error("m_we not a single cycle after MEM_ADDR");
            err_count++;
        end

    fetch_then_decode_a: assert property (fetch_then_decode)
        else begin
            $error("FETCH not followed by DECODE");
            err_count++;
        end

    error_is_final_a: assert property (error_is_final)
        else begin
            $error("controller left ERROR without reset");
            err_count++;
        end

    no_rf_write_in_fetch_a: assert property (no_rf_write_in_fetch)
        else begin
            $error("register write enable high during FETCH");
            err_count++;
        end

endmodule

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam int            MEM_WORDS  = 256;    // 1 KiB
    localparam rv_pkg::word_t STORE_BASE = 32'h0000_0200;

    logic          clk;
    logic          rst;
    rv_pkg::word_t mem_addr;
    rv_pkg::word_t mem_wdata;
    logic          mem_we;
    rv_pkg::word_t mem_rdata;
    logic          trap;

    rv_pkg::word_t mem [MEM_WORDS];
    rv_pkg::word_t ref_mem [MEM_WORDS];
    rv_pkg::word_t ref_regs [32];
    rv_pkg::word_t ref_pc;
    logic [63:0]   obs_q [$];    // {addr, data}
    logic [63:0]   exp_q [$];
    integer        seed;
    int            prog_len;
    int            store_off;
    int            timeout_cycles;
    logic          prog_ready;

    rv_core rv_core_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata),
        .trap      (trap)
    );

    bind rv_controller rv_core_sva sva_inst (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .m_we  (m_we),
        .rf_we (rf_we)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    assign mem_rdata = mem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr[9:2]] <= mem_wdata;
            obs_q.push_back({mem_addr, mem_wdata});
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input rv_pkg::word_t got,
                               input rv_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input rv_pkg::reg_idx_t rd,
                                            input rv_pkg::reg_idx_t rs1,
                                            input rv_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_R_TYPE};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [6:0] op, input rv_pkg::reg_idx_t rd,
                                            input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_s(input rv_pkg::reg_idx_t rs2,
                                            input rv_pkg::reg_idx_t rs1,
                                            input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], rv_pkg::OP_S_TYPE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
                                            input rv_pkg::reg_idx_t rs2,
                                            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_B_TYPE};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [6:0] op, input rv_pkg::reg_idx_t rd,
                                            input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_j(input rv_pkg::reg_idx_t rd,
                                            input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_J_TYPE};
    endfunction

    task automatic emit(input rv_pkg::word_t w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_store(input rv_pkg::reg_idx_t rs);
        emit(enc_s(rs, 5'd31, store_off[11:0]));    // x31 holds STORE_BASE
        store_off += 4;
    endtask

    task automatic emit_branch(input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
                               input rv_pkg::reg_idx_t rs2);
        emit(enc_b(f3, rs1, rs2, 13'd8));
        emit_store(5'd6);    // fall-through marker
        emit_store(5'd7);
    endtask

    task automatic build_program();
        rv_pkg::word_t r1;
        rv_pkg::word_t r2;
        int            off;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hc0de_0000 | (i << 2);
        prog_len  = 0;
        store_off = 0;
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd31, 3'd0, 5'd0, STORE_BASE[11:0]));
        r1 = $random(seed);
        r2 = $random(seed);
        emit(enc_u(rv_pkg::OP_LUI, 5'd1, r1[31:12]));
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd1, 3'd0, 5'd1, r1[11:0]));
        emit(enc_u(rv_pkg::OP_LUI, 5'd2, r2[31:12]));
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd2, 3'd0, 5'd2, r2[11:0]));
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'b0000000, f[2:0], 5'd3, 5'd1, 5'd2));
            emit_store(5'd3);
        end
        emit(enc_r(7'b0100000, 3'd0, 5'd3, 5'd1, 5'd2));    // sub
        emit_store(5'd3);
        emit(enc_r(7'b0100000, 3'd5, 5'd3, 5'd1, 5'd2));    // sra
        emit_store(5'd3);
        for (int f = 0; f < 8; f++) begin
            r1 = $random(seed);
            if (f == 1 || f == 5)
                r1[11:5] = 7'd0;    // shamt only
            emit(enc_i(rv_pkg::OP_I_TYPE, 5'd3, f[2:0], 5'd1, r1[11:0]));
            emit_store(5'd3);
        end
        r1 = $random(seed);
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd3, 3'd5, 5'd1, {7'b0100000, r1[4:0]}));    // srai
        emit_store(5'd3);
        off = store_off;
        emit_store(5'd1);
        emit(enc_i(rv_pkg::OP_I_TYPE_L, 5'd4, 3'b010, 5'd31, off[11:0]));
        emit_store(5'd4);
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd8, 3'd0, 5'd0, 12'hffb));    // -5
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd9, 3'd0, 5'd0, 12'd7));
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd10, 3'd0, 5'd0, 12'hffb));
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd6, 3'd0, 5'd0, 12'h111));
        emit(enc_i(rv_pkg::OP_I_TYPE, 5'd7, 3'd0, 5'd0, 12'h222));
        emit_branch(3'd0, 5'd8, 5'd10);
        emit_branch(3'd0, 5'd8, 5'd9);
        emit_branch(3'd1, 5'd8, 5'd9);
        emit_branch(3'd1, 5'd8, 5'd10);
        emit_branch(3'd4, 5'd8, 5'd9);
        emit_branch(3'd4, 5'd9, 5'd8);
        emit_branch(3'd5, 5'd9, 5'd8);
        emit_branch(3'd5, 5'd8, 5'd9);
        emit_branch(3'd6, 5'd9, 5'd8);    // 7 below 0xfffffffb unsigned
        emit_branch(3'd6, 5'd8, 5'd9);
        emit_branch(3'd7, 5'd8, 5'd9);
        emit_branch(3'd7, 5'd9, 5'd8);
        emit(enc_j(5'd11, 21'd8));
        emit_store(5'd6);    // skipped
        emit_store(5'd11);
        emit(enc_u(rv_pkg::OP_AUIPC, 5'd12, 20'd0));
        emit(enc_i(rv_pkg::OP_JALR, 5'd13, 3'd0, 5'd12, 12'd13));    // odd target
        emit_store(5'd6);    // skipped
        emit_store(5'd13);
        emit_store(5'd12);
        r1 = $random(seed);
        emit(enc_u(rv_pkg::OP_LUI, 5'd14, r1[31:12]));
        emit_store(5'd14);
        r1 = $random(seed);
        emit(enc_u(rv_pkg::OP_AUIPC, 5'd15, r1[31:12]));
        emit_store(5'd15);
        emit(32'h0000_0000);    // unknown opcode
    endtask

    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // one ISA step on the model state, returns 1 on an unknown opcode
    function automatic logic ref_step();
        rv_pkg::word_t ins;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t imm_i;
        rv_pkg::word_t addr;
        rv_pkg::word_t res;
        rv_pkg::word_t nxt;
        logic [2:0]    f3;
        logic          wr;
        logic          take;
        ins   = ref_mem[ref_pc[9:2]];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        nxt   = ref_pc + 32'd4;
        res   = '0;
        wr    = 1'b1;
        case (ins[6:0])
            rv_pkg::OP_R_TYPE: res = alu_ref(f3, ins[30], a, b);
            rv_pkg::OP_I_TYPE: res = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
            rv_pkg::OP_I_TYPE_L: begin
                addr = a + imm_i;
                res  = ref_mem[addr[9:2]];
            end
            rv_pkg::OP_S_TYPE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                ref_mem[addr[9:2]] = b;
                exp_q.push_back({addr, b});
                wr = 1'b0;
            end
            rv_pkg::OP_B_TYPE: begin
                case (f3)
                    3'd0:    take = a == b;
                    3'd1:    take = a != b;
                    3'd4:    take = $signed(a) < $signed(b);
                    3'd5:    take = $signed(a) >= $signed(b);
                    3'd6:    take = a < b;
                    default: take = a >= b;
                endcase
                if (take)
                    nxt = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                wr = 1'b0;
            end
            rv_pkg::OP_J_TYPE: begin
                res = ref_pc + 32'd4;
                nxt = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_pkg::OP_JALR: begin
                res = ref_pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            rv_pkg::OP_LUI:   res = {ins[31:12], 12'd0};
            rv_pkg::OP_AUIPC: res = ref_pc + {ins[31:12], 12'd0};
            default:          return 1'b1;
        endcase
        if (wr && ins[11:7] != 5'd0)
            ref_regs[ins[11:7]] = res;
        ref_pc = nxt;
        return 1'b0;
    endfunction

    task automatic run_reference();
        int steps;
        ref_mem = mem;
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        ref_pc = rv_pkg::RESET_PC;
        steps  = 0;
        while (!ref_step()) begin
            steps++;
            if (steps > 4 * MEM_WORDS)
                abort_run("reference model never reached the illegal opcode");
        end
    endtask

    always @(negedge clk) begin : compare_stores
        logic [63:0] got;
        logic [63:0] want;
        if (rv_core_inst.controller_inst.sva_inst.err_count != 0)
            abort_run("an assertion on the controller failed");
        while (obs_q.size() > 0) begin
            got = obs_q.pop_front();
            if (exp_q.size() == 0)
                abort_run($sformatf("unexpected extra store to address 0x%08h", got[63:32]));
            want = exp_q.pop_front();
            check_value("mem_addr", got[63:32], want[63:32]);
            check_value("mem_wdata", got[31:0], want[31:0]);
        end
    end

    initial begin
        wait (prog_ready === 1'b1);
        repeat (timeout_cycles + 8) @(posedge clk);
        abort_run($sformatf("timeout: trap did not rise within %0d cycles", timeout_cycles));
    end

    initial begin
        rst        = 1'b1;
        prog_ready = 1'b0;
        seed       = 32'h09956e24;
        build_program();
        run_reference();
        timeout_cycles = 5 * prog_len + 40;
        prog_ready     = 1'b1;
        repeat (8) @(posedge clk);
        check_value("mem_we", {31'd0, mem_we}, 32'd0);    // still held in reset
        check_value("trap", {31'd0, trap}, 32'd0);
        rst <= 1'b0;
        wait (trap === 1'b1);
        repeat (6) @(posedge clk);    // room for a stray store after trap
        if (exp_q.size() == 0 && obs_q.size() == 0 &&
            rv_core_inst.controller_inst.sva_inst.err_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected stores missing, %0d assertion failures",
                                exp_q.size(), rv_core_inst.controller_inst.sva_inst.err_count));
        end
    end

endmodule

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::word_t      a,
    input  rv_pkg::word_t      b,
    input  rv_pkg::alu_op_e    alu_op,
    output rv_pkg::word_t      result,
    output rv_pkg::alu_flags_t flags
);

    logic [32:0] sum;
    logic [32:0] diff;
    logic        carry;
    logic        overflow;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 33'd1;    // bit 32 set means no borrow

    always_comb begin
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (alu_op)
            rv_pkg::ALU_OP_ADD: begin
                result   = sum[31:0];
                carry    = sum[32];
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            rv_pkg::ALU_OP_SUB: begin
                result   = diff[31:0];
                carry    = diff[32];
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            rv_pkg::ALU_OP_AND:  result = a & b;
            rv_pkg::ALU_OP_OR:   result = a | b;
            rv_pkg::ALU_OP_XOR:  result = a ^ b;
            rv_pkg::ALU_OP_SLL:  result = a << b[4:0];
            rv_pkg::ALU_OP_SRL:  result = a >> b[4:0];
            rv_pkg::ALU_OP_SRA:  result = $signed(a) >>> b[4:0];
            rv_pkg::ALU_OP_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            rv_pkg::ALU_OP_SLTU: result = {31'd0, a < b};
            default:             result = '0;
        endcase
    end

    assign flags = {result[31], result == 32'd0, carry, overflow};

endmodule

// ==== verilog/rv_controller.sv ====
`timescale 1ns/1ps

module rv_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_pkg::word_t        instr,
    input  rv_pkg::alu_flags_t   alu_flags,
    output logic                 rf_we,
    output logic                 m_we,
    output logic                 en_ir,
    output logic                 en_npc_r,
    output logic                 en_oldpc_r,
    output logic                 m_addr_src,
    output rv_pkg::alu_src_e     alu_src_a,
    output rv_pkg::alu_src_e     alu_src_b,
    output rv_pkg::imm_src_e     imm_src,
    output rv_pkg::res_src_e     res_src,
    output rv_pkg::rf_wd_src_e   rf_wd_src,
    output rv_pkg::alu_op_e      alu_op,
    output logic                 trap
);

    logic [6:0]        op;
    logic [2:0]        funct3;
    rv_pkg::rv_state_e state;
    rv_pkg::rv_state_e state_next;
    rv_pkg::rv_state_e decode_ns;
    rv_pkg::alu_op_e   dec_op;
    logic              flag_n;
    logic              flag_z;
    logic              flag_c;
    logic              flag_v;
    logic              take_branch;

    assign op     = instr[6:0];
    assign funct3 = instr[14:12];
    assign {flag_n, flag_z, flag_c, flag_v} = alu_flags;

    always_comb begin
        case (op)
            rv_pkg::OP_R_TYPE:   decode_ns = rv_pkg::EXEC_R;
            rv_pkg::OP_I_TYPE:   decode_ns = rv_pkg::EXEC_I;
            rv_pkg::OP_JALR:     decode_ns = rv_pkg::EXEC_I_JALR;
            rv_pkg::OP_I_TYPE_L: decode_ns = rv_pkg::MEM_ADDR;
            rv_pkg::OP_S_TYPE:   decode_ns = rv_pkg::MEM_ADDR;
            rv_pkg::OP_B_TYPE:   decode_ns = rv_pkg::BRANCH;
            rv_pkg::OP_J_TYPE:   decode_ns = rv_pkg::EXEC_J;
            rv_pkg::OP_LUI:      decode_ns = rv_pkg::EXEC_LUI;
            rv_pkg::OP_AUIPC:    decode_ns = rv_pkg::EXEC_AUIPC;
            default:             decode_ns = rv_pkg::ERROR;    // unknown opcode
        endcase
    end

    always_comb begin
        case (state)
            rv_pkg::FETCH:    state_next = rv_pkg::DECODE;
            rv_pkg::DECODE:   state_next = decode_ns;
            rv_pkg::MEM_ADDR:
                state_next = (op == rv_pkg::OP_I_TYPE_L) ? rv_pkg::MEM_READ : rv_pkg::MEM_WRITE;
            rv_pkg::MEM_READ:    state_next = rv_pkg::MEM_W_RF;
            rv_pkg::EXEC_R:      state_next = rv_pkg::ALU_W_RF;
            rv_pkg::EXEC_I:      state_next = rv_pkg::ALU_W_RF;
            rv_pkg::EXEC_I_JALR: state_next = rv_pkg::ALU_W_PCN;
            rv_pkg::ERROR:       state_next = rv_pkg::ERROR;    // held until reset
            default:             state_next = rv_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= rv_pkg::FETCH;
        else
            state <= state_next;
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_op = (op == rv_pkg::OP_R_TYPE && instr[30]) ?
                              rv_pkg::ALU_OP_SUB : rv_pkg::ALU_OP_ADD;
            3'b001:  dec_op = rv_pkg::ALU_OP_SLL;
            3'b010:  dec_op = rv_pkg::ALU_OP_SLT;
            3'b011:  dec_op = rv_pkg::ALU_OP_SLTU;
            3'b100:  dec_op = rv_pkg::ALU_OP_XOR;
            3'b101:  dec_op = instr[30] ? rv_pkg::ALU_OP_SRA : rv_pkg::ALU_OP_SRL;
            3'b110:  dec_op = rv_pkg::ALU_OP_OR;
            default: dec_op = rv_pkg::ALU_OP_AND;
        endcase
    end

    always_comb begin
        case (state)
            rv_pkg::EXEC_R, rv_pkg::EXEC_I: alu_op = dec_op;
            rv_pkg::BRANCH:                 alu_op = rv_pkg::ALU_OP_SUB;    // compare via flags
            rv_pkg::FETCH, rv_pkg::DECODE, rv_pkg::MEM_ADDR, rv_pkg::EXEC_I_JALR:
                alu_op = rv_pkg::ALU_OP_ADD;
            default:                        alu_op = rv_pkg::ALU_OP_NONE;
        endcase
    end

    always_comb begin
        case (state)
            rv_pkg::DECODE: begin
                case (op)
                    rv_pkg::OP_B_TYPE: imm_src = rv_pkg::IMM_SRC_B;
                    rv_pkg::OP_J_TYPE: imm_src = rv_pkg::IMM_SRC_J;
                    rv_pkg::OP_AUIPC:  imm_src = rv_pkg::IMM_SRC_U;
                    default:           imm_src = rv_pkg::IMM_SRC_NONE;
                endcase
            end
            rv_pkg::MEM_ADDR:
                imm_src = (op == rv_pkg::OP_I_TYPE_L) ? rv_pkg::IMM_SRC_I : rv_pkg::IMM_SRC_S;
            rv_pkg::EXEC_I:    // slli, srli, srai
                imm_src = (funct3[1:0] == 2'b01) ? rv_pkg::IMM_SRC_I_SHIFT : rv_pkg::IMM_SRC_I;
            rv_pkg::EXEC_I_JALR: imm_src = rv_pkg::IMM_SRC_I;
            rv_pkg::EXEC_LUI:    imm_src = rv_pkg::IMM_SRC_U;
            default:             imm_src = rv_pkg::IMM_SRC_NONE;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  take_branch = flag_z;                 // beq
            3'b001:  take_branch = !flag_z;                // bne
            3'b100:  take_branch = flag_n ^ flag_v;        // blt
            3'b101:  take_branch = !(flag_n ^ flag_v);     // bge
            3'b110:  take_branch = !flag_c;                // bltu, borrow
            3'b111:  take_branch = flag_c;                 // bgeu
            default: take_branch = 1'b0;
        endcase
    end

    assign en_npc_r = (state inside {rv_pkg::FETCH, rv_pkg::EXEC_J, rv_pkg::ALU_W_PCN}) ||
                      (state == rv_pkg::BRANCH && take_branch);

    always_comb begin
        alu_src_a = rv_pkg::ALU_SRC_NONE;
        alu_src_b = rv_pkg::ALU_SRC_NONE;
        case (state)
            rv_pkg::FETCH: begin
                alu_src_a = rv_pkg::ALU_SRC_PC;
                alu_src_b = rv_pkg::ALU_SRC_FOUR;
            end
            rv_pkg::DECODE: begin    // branch, jal and auipc target
                alu_src_a = rv_pkg::ALU_SRC_PC_OLD;
                alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::MEM_ADDR, rv_pkg::EXEC_I, rv_pkg::EXEC_I_JALR: begin
                alu_src_a = rv_pkg::ALU_SRC_REG_1;
                alu_src_b = rv_pkg::ALU_SRC_EXT_IMM;
            end
            rv_pkg::EXEC_R, rv_pkg::BRANCH: begin
                alu_src_a = rv_pkg::ALU_SRC_REG_1;
                alu_src_b = rv_pkg::ALU_SRC_REG_2;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            rv_pkg::MEM_W_RF:    res_src = rv_pkg::RES_SRC_MEM;
            rv_pkg::ALU_W_RF, rv_pkg::EXEC_AUIPC:
                res_src = rv_pkg::RES_SRC_ALU_OUT;
            default:             res_src = rv_pkg::RES_SRC_NONE;
        endcase
    end

    always_comb begin
        case (state)
            rv_pkg::MEM_W_RF, rv_pkg::ALU_W_RF, rv_pkg::EXEC_AUIPC:
                rf_wd_src = rv_pkg::RF_WD_SRC_RES;
            rv_pkg::EXEC_I_JALR, rv_pkg::EXEC_J:
                rf_wd_src = rv_pkg::RF_WD_SRC_PC;
            rv_pkg::EXEC_LUI:    rf_wd_src = rv_pkg::RF_WD_SRC_IMM;
            default:             rf_wd_src = rv_pkg::RF_WD_SRC_NONE;
        endcase
    end

    assign rf_we      = rf_wd_src != rv_pkg::RF_WD_SRC_NONE;    // every writing state picks a source
    assign m_we       = state == rv_pkg::MEM_WRITE;
    assign en_ir      = state == rv_pkg::FETCH;
    assign en_oldpc_r = state == rv_pkg::FETCH;
    assign m_addr_src = state inside {rv_pkg::MEM_READ, rv_pkg::MEM_WRITE};
    assign trap       = state == rv_pkg::ERROR;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic          mem_we,
    input  rv_pkg::word_t mem_rdata,
    output logic          trap
);

    rv_pkg::word_t      instr;
    rv_pkg::alu_flags_t alu_flags;
    logic               rf_we;
    logic               en_ir;
    logic               en_npc_r;
    logic               en_oldpc_r;
    logic               m_addr_src;
    rv_pkg::alu_src_e   alu_src_a;
    rv_pkg::alu_src_e   alu_src_b;
    rv_pkg::imm_src_e   imm_src;
    rv_pkg::res_src_e   res_src;
    rv_pkg::rf_wd_src_e rf_wd_src;
    rv_pkg::alu_op_e    alu_op;
    rv_pkg::word_t      alu_a;
    rv_pkg::word_t      alu_b;
    rv_pkg::word_t      alu_result;
    rv_pkg::reg_idx_t   rs1;
    rv_pkg::reg_idx_t   rs2;
    rv_pkg::reg_idx_t   rd;
    rv_pkg::word_t      rf_wd;
    rv_pkg::word_t      rd1;
    rv_pkg::word_t      rd2;

    rv_controller controller_inst (.*, .m_we(mem_we));    // matching names otherwise

    rv_datapath datapath_inst (.*);

    rv_alu alu_inst (
        .a      (alu_a),
        .b      (alu_b),
        .alu_op (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    rv_regfile regfile_inst (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd  (rd),
        .wd  (rf_wd),
        .we  (rf_we),
        .rd1 (rd1),
        .rd2 (rd2)
    );

endmodule

// ==== verilog/rv_datapath.sv ====
`timescale 1ns/1ps

module rv_datapath (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_ir,
    input  logic               en_npc_r,
    input  logic               en_oldpc_r,
    input  logic               m_addr_src,
    input  rv_pkg::alu_src_e   alu_src_a,
    input  rv_pkg::alu_src_e   alu_src_b,
    input  rv_pkg::imm_src_e   imm_src,
    input  rv_pkg::res_src_e   res_src,
    input  rv_pkg::rf_wd_src_e rf_wd_src,
    input  rv_pkg::word_t      mem_rdata,
    output rv_pkg::word_t      mem_addr,
    output rv_pkg::word_t      mem_wdata,
    output rv_pkg::word_t      instr,
    output rv_pkg::word_t      alu_a,
    output rv_pkg::word_t      alu_b,
    input  rv_pkg::word_t      alu_result,
    output rv_pkg::reg_idx_t   rs1,
    output rv_pkg::reg_idx_t   rs2,
    output rv_pkg::reg_idx_t   rd,
    output rv_pkg::word_t      rf_wd,
    input  rv_pkg::word_t      rd1,
    input  rv_pkg::word_t      rd2
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;
    rv_pkg::word_t old_pc;
    rv_pkg::word_t ir;
    rv_pkg::word_t data_r;
    rv_pkg::word_t alu_out_r;
    rv_pkg::word_t imm;
    rv_pkg::word_t result;

    function automatic rv_pkg::word_t pick_operand(
        input rv_pkg::alu_src_e sel,
        input rv_pkg::word_t    pc_v,
        input rv_pkg::word_t    old_pc_v,
        input rv_pkg::word_t    r1,
        input rv_pkg::word_t    r2,
        input rv_pkg::word_t    imm_v
    );
        case (sel)
            rv_pkg::ALU_SRC_PC:      return pc_v;
            rv_pkg::ALU_SRC_PC_OLD:  return old_pc_v;
            rv_pkg::ALU_SRC_REG_1:   return r1;
            rv_pkg::ALU_SRC_REG_2:   return r2;
            rv_pkg::ALU_SRC_EXT_IMM: return imm_v;
            rv_pkg::ALU_SRC_FOUR:    return 32'd4;
            default:                 return '0;
        endcase
    endfunction

    // fetch takes pc+4 straight off the alu, later loads use the latched target
    assign pc_next = en_ir ? alu_result : {alu_out_r[31:1], 1'b0};    // jalr lsb cleared

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= rv_pkg::RESET_PC;
            ir <= '0;
        end else begin
            if (en_npc_r)
                pc <= pc_next;
            if (en_ir)
                ir <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (en_oldpc_r)
            old_pc <= pc;
        data_r    <= mem_rdata;
        alu_out_r <= alu_result;
    end

    always_comb begin
        case (imm_src)
            rv_pkg::IMM_SRC_I:       imm = {{20{ir[31]}}, ir[31:20]};
            rv_pkg::IMM_SRC_I_SHIFT: imm = {27'd0, ir[24:20]};
            rv_pkg::IMM_SRC_S:       imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            rv_pkg::IMM_SRC_B:       imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            rv_pkg::IMM_SRC_U:       imm = {ir[31:12], 12'd0};
            rv_pkg::IMM_SRC_J:
                imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:                 imm = '0;
        endcase
    end

    always_comb begin
        alu_a = pick_operand(alu_src_a, pc, old_pc, rd1, rd2, imm);
        alu_b = pick_operand(alu_src_b, pc, old_pc, rd1, rd2, imm);
    end

    always_comb begin
        case (res_src)
            rv_pkg::RES_SRC_ALU_OUT: result = alu_out_r;
            rv_pkg::RES_SRC_MEM:     result = data_r;
            default:                 result = '0;
        endcase
    end

    always_comb begin
        case (rf_wd_src)
            rv_pkg::RF_WD_SRC_RES: rf_wd = result;
            rv_pkg::RF_WD_SRC_PC:  rf_wd = old_pc + 32'd4;    // link address
            rv_pkg::RF_WD_SRC_IMM: rf_wd = imm;
            default:               rf_wd = '0;
        endcase
    end

    assign instr     = ir;
    assign rs1       = ir[19:15];
    assign rs2       = ir[24:20];
    assign rd        = ir[11:7];
    assign mem_addr  = m_addr_src ? alu_out_r : pc;
    assign mem_wdata = rd2;

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] alu_flags_t;    // n, z, c, v

    localparam logic [6:0] OP_R_TYPE   = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE   = 7'b0010011;
    localparam logic [6:0] OP_I_TYPE_L = 7'b0000011;   // loads
    localparam logic [6:0] OP_S_TYPE   = 7'b0100011;
    localparam logic [6:0] OP_B_TYPE   = 7'b1100011;
    localparam logic [6:0] OP_J_TYPE   = 7'b1101111;   // jal
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;

    localparam word_t RESET_PC = 32'h0000_0000;

    typedef enum logic [3:0] {
        FETCH, DECODE, MEM_ADDR, MEM_READ,
        MEM_WRITE, MEM_W_RF, EXEC_R, ALU_W_RF,
        BRANCH, EXEC_I, ALU_W_PCN, EXEC_I_JALR,
        EXEC_J, EXEC_LUI, EXEC_AUIPC, ERROR
    } rv_state_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_SRC_PC,
        ALU_SRC_PC_OLD,
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_EXT_IMM,
        ALU_SRC_FOUR,
        ALU_SRC_NONE
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_SRC_I,
        IMM_SRC_I_SHIFT,    // shamt only
        IMM_SRC_S,
        IMM_SRC_B,
        IMM_SRC_U,
        IMM_SRC_J,
        IMM_SRC_NONE
    } imm_src_e;

    typedef enum logic [1:0] {RES_SRC_ALU_OUT, RES_SRC_MEM, RES_SRC_NONE} res_src_e;

    typedef enum logic [1:0] {
        RF_WD_SRC_RES,
        RF_WD_SRC_PC,       // link address
        RF_WD_SRC_IMM,
        RF_WD_SRC_NONE
    } rf_wd_src_e;

endpackage

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wd,
    input  logic             we,
    output rv_pkg::word_t    rd1,
    output rv_pkg::word_t    rd2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin    // x0 never written
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule
